// ==== rtl/types_amba_pkg.sv ====
// AMBA APB bus types
// Address and data widths plus the request and response
// bundles that travel between the master, the decoder and the slaves

`default_nettype none

package types_amba_pkg;

localparam int APB_ADDR_WIDTH = 32;
localparam int APB_DATA_WIDTH = 32;

typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

// Master to slave
typedef struct packed {
    apb_addr_t paddr;
    logic pwrite;
    apb_data_t pwdata;
    logic psel;                             // Setup and access phases
    logic penable;                          // Access phase only
} apb_in_type;

// Slave to master
typedef struct packed {
    apb_data_t prdata;
    logic pready;
    logic pslverr;
} apb_out_type;

endpackage: types_amba_pkg

`default_nettype wire

// ==== rtl/soc_cfg_pkg.sv ====
// Peripheral subsystem configuration
// Address map of the APB slots, interrupt numbering and
// the device descriptor table reported by the plug-and-play block

`default_nettype none

package soc_cfg_pkg;

// Slot indices on the peripheral bus
localparam int SLOT_GPIO = 0;
localparam int SLOT_IRQCTRL = 1;
localparam int SLOT_PNP = 2;
localparam int SLOT_TOTAL = 3;

localparam int SLOT_SIZE_LOG2 = 12;         // 4 KB per slot

typedef logic [SLOT_TOTAL-1:0] slot_sel_t;
typedef logic [SLOT_SIZE_LOG2-3:0] reg_idx_t;   // Word index inside a slot

// Everything from 0x3000 up is unmapped
localparam logic [31:0] SLOT_BASE [SLOT_TOTAL] = '{32'h0000_0000, 32'h0000_1000, 32'h0000_2000};

typedef struct packed {
    logic [15:0] vid;
    logic [15:0] did;
    logic [31:0] addr_base;
} dev_config_type;

localparam logic [15:0] VENDOR_ID = 16'h00f1;
localparam logic [31:0] HW_ID = 32'h5ec0_0001;

// Ordered by slot index
localparam dev_config_type DEV_TABLE [SLOT_TOTAL] = '{
    '{vid: VENDOR_ID, did: 16'h0101, addr_base: SLOT_BASE[SLOT_GPIO]},
    '{vid: VENDOR_ID, did: 16'h0102, addr_base: SLOT_BASE[SLOT_IRQCTRL]},
    '{vid: VENDOR_ID, did: 16'h0103, addr_base: SLOT_BASE[SLOT_PNP]}
};

// Interrupt sources of the controller
localparam int IRQ_TOTAL = 16;
localparam int IRQ_GPIO_BASE = 0;
localparam int IRQ_PNP = 12;

typedef logic [IRQ_TOTAL-1:0] irq_vec_t;

endpackage: soc_cfg_pkg

`default_nettype wire

// ==== rtl/apb_bus1.sv ====
// APB peripheral bridge decoder
// Selects one slave slot from the upper address bits, passes the
// slot offset down and returns the selected slave response.
// Unmapped addresses get an error response with zero data

`timescale 1ns/10ps
`default_nettype none

module apb_bus1 (
    input logic i_clk,
    input logic i_rst,
    input types_amba_pkg::apb_in_type i_apbi,                       // From system bus side
    output types_amba_pkg::apb_out_type o_apbo,
    output types_amba_pkg::apb_in_type o_slv_apbi [soc_cfg_pkg::SLOT_TOTAL],
    input types_amba_pkg::apb_out_type i_slv_apbo [soc_cfg_pkg::SLOT_TOTAL]
);

localparam int ADDR_LSB = soc_cfg_pkg::SLOT_SIZE_LOG2;
localparam int ADDR_MSB = $bits(types_amba_pkg::apb_addr_t) - 1;

soc_cfg_pkg::slot_sel_t slot_hit;
soc_cfg_pkg::slot_sel_t slot_sel;

always_comb
begin: decode_proc
    for (int k = 0; k < soc_cfg_pkg::SLOT_TOTAL; k++)
    begin
        slot_hit[k] = (i_apbi.paddr[ADDR_MSB:ADDR_LSB]
                       == soc_cfg_pkg::SLOT_BASE[k][ADDR_MSB:ADDR_LSB]);
    end
end: decode_proc

assign slot_sel = slot_hit & {soc_cfg_pkg::SLOT_TOTAL{i_apbi.psel}};

always_comb
begin: slave_req_proc
    for (int k = 0; k < soc_cfg_pkg::SLOT_TOTAL; k++)
    begin
        o_slv_apbi[k] = i_apbi;
        o_slv_apbi[k].paddr = types_amba_pkg::apb_addr_t'(i_apbi.paddr[ADDR_LSB-1:0]);
        o_slv_apbi[k].psel = slot_sel[k];
        o_slv_apbi[k].penable = slot_sel[k] & i_apbi.penable;
    end
end: slave_req_proc

always_comb
begin: resp_proc
    // Unmapped response unless a slot matches
    o_apbo.prdata = '0;
    o_apbo.pready = 1'b1;
    o_apbo.pslverr = 1'b1;
    for (int k = 0; k < soc_cfg_pkg::SLOT_TOTAL; k++)
    begin
        if (slot_hit[k])
        begin
            o_apbo = i_slv_apbo[k];
        end
    end
end: resp_proc

a_penable_needs_psel: assert property (
    @(posedge i_clk) disable iff (i_rst) i_apbi.penable |-> i_apbi.psel);

a_slot_onehot: assert property (
    @(posedge i_clk) disable iff (i_rst) $onehot0(slot_sel));

endmodule: apb_bus1

`default_nettype wire

// ==== rtl/apb_gpio.sv ====
// APB GPIO block
// Output value, direction and interrupt enable registers, a two-flop
// input synchronizer and rising-edge pending bits cleared by write 1.
// Each interrupt line is the pending bit masked by its enable

`timescale 1ns/10ps
`default_nettype none

module apb_gpio #(
    parameter int gpio_width = 12
)
(
    input logic i_clk,
    input logic i_rst,
    input types_amba_pkg::apb_in_type i_apbi,
    output types_amba_pkg::apb_out_type o_apbo,
    input logic [gpio_width-1:0] i_gpio,
    output logic [gpio_width-1:0] o_gpio,
    output logic [gpio_width-1:0] o_gpio_dir,                  // 1 = output
    output logic [gpio_width-1:0] o_irq
);

typedef logic [gpio_width-1:0] gpio_vec_t;

localparam soc_cfg_pkg::reg_idx_t REG_INPUT = 'h0;      // 0x00
localparam soc_cfg_pkg::reg_idx_t REG_OUTPUT = 'h1;     // 0x04
localparam soc_cfg_pkg::reg_idx_t REG_DIR = 'h2;        // 0x08
localparam soc_cfg_pkg::reg_idx_t REG_IE = 'h3;         // 0x0C
localparam soc_cfg_pkg::reg_idx_t REG_PENDING = 'h4;    // 0x10

gpio_vec_t sync1;
gpio_vec_t sync2;
gpio_vec_t sync2_d;                         // Previous synced value for edge detect
gpio_vec_t out_r;
gpio_vec_t dir_r;
gpio_vec_t ie_r;
gpio_vec_t ip_r;
gpio_vec_t rise;
gpio_vec_t ip_clr;
soc_cfg_pkg::reg_idx_t reg_idx;
logic wr_en;

assign reg_idx = i_apbi.paddr[soc_cfg_pkg::SLOT_SIZE_LOG2-1:2];
assign wr_en = i_apbi.psel & i_apbi.penable & i_apbi.pwrite;
assign rise = sync2 & ~sync2_d;
assign ip_clr = (wr_en && reg_idx == REG_PENDING) ? i_apbi.pwdata[gpio_width-1:0] : '0;

always_ff @(posedge i_clk)
begin: regs_proc
    if (i_rst)
    begin
        sync1 <= '0;
        sync2 <= '0;
        sync2_d <= '0;
        out_r <= '0;
        dir_r <= '0;
        ie_r <= '0;
        ip_r <= '0;
    end
    else
    begin
        sync1 <= i_gpio;
        sync2 <= sync1;
        sync2_d <= sync2;
        if (wr_en && reg_idx == REG_OUTPUT)
        begin
            out_r <= i_apbi.pwdata[gpio_width-1:0];
        end
        if (wr_en && reg_idx == REG_DIR)
        begin
            dir_r <= i_apbi.pwdata[gpio_width-1:0];
        end
        if (wr_en && reg_idx == REG_IE)
        begin
            ie_r <= i_apbi.pwdata[gpio_width-1:0];
        end
        ip_r <= (ip_r & ~ip_clr) | rise;    // New edge beats the clear
    end
end: regs_proc

always_comb
begin: read_proc
    o_apbo.prdata = '0;
    o_apbo.pready = 1'b1;
    o_apbo.pslverr = 1'b0;
    case (reg_idx)
    REG_INPUT: o_apbo.prdata = types_amba_pkg::apb_data_t'(sync2);
    REG_OUTPUT: o_apbo.prdata = types_amba_pkg::apb_data_t'(out_r);
    REG_DIR: o_apbo.prdata = types_amba_pkg::apb_data_t'(dir_r);
    REG_IE: o_apbo.prdata = types_amba_pkg::apb_data_t'(ie_r);
    REG_PENDING: o_apbo.prdata = types_amba_pkg::apb_data_t'(ip_r);
    default: o_apbo.prdata = '0;
    endcase
end: read_proc

assign o_gpio = out_r;
assign o_gpio_dir = dir_r;
assign o_irq = ip_r & ie_r;

// A rising edge pends even against a write 1 clear in the same cycle
a_edge_sets_pending: assert property (
    @(posedge i_clk) disable iff (i_rst) rise != '0 |=> (ip_r & $past(rise)) == $past(rise));

endmodule: apb_gpio

`default_nettype wire

// ==== rtl/apb_irqctrl.sv ====
// APB platform interrupt controller
// Sources set pending bits on their level every cycle. A claim read
// returns the lowest enabled pending source plus 1 and clears it.
// Machine external interrupt is raised while anything enabled is pending

`timescale 1ns/10ps
`default_nettype none

module apb_irqctrl (
    input logic i_clk,
    input logic i_rst,
    input types_amba_pkg::apb_in_type i_apbi,
    output types_amba_pkg::apb_out_type o_apbo,
    input soc_cfg_pkg::irq_vec_t i_irq_request,
    output logic o_meip
);

typedef logic [$clog2(soc_cfg_pkg::IRQ_TOTAL + 1)-1:0] claim_id_t;

localparam soc_cfg_pkg::reg_idx_t REG_PENDING = 'h0;
localparam soc_cfg_pkg::reg_idx_t REG_ENABLE = 'h1;
localparam soc_cfg_pkg::reg_idx_t REG_CLAIM = 'h2;

soc_cfg_pkg::irq_vec_t ip_r;
soc_cfg_pkg::irq_vec_t ie_r;
soc_cfg_pkg::irq_vec_t active;
soc_cfg_pkg::irq_vec_t claim_vec;           // One-hot of the claimed source
claim_id_t claim_id;
soc_cfg_pkg::reg_idx_t reg_idx;
logic access;
logic claim_rd;

assign reg_idx = i_apbi.paddr[soc_cfg_pkg::SLOT_SIZE_LOG2-1:2];
assign access = i_apbi.psel & i_apbi.penable;
assign claim_rd = access & ~i_apbi.pwrite & (reg_idx == REG_CLAIM);
assign active = ip_r & ie_r;

// Lowest index wins, so scan from the top down
always_comb
begin: claim_proc
    claim_id = '0;
    claim_vec = '0;
    for (int i = soc_cfg_pkg::IRQ_TOTAL - 1; i >= 0; i--)
    begin
        if (active[i])
        begin
            claim_id = claim_id_t'(i + 1);
            claim_vec = '0;
            claim_vec[i] = 1'b1;
        end
    end
end: claim_proc

always_ff @(posedge i_clk)
begin: regs_proc
    if (i_rst)
    begin
        ip_r <= '0;
        ie_r <= '0;
    end
    else
    begin
        // Source still high pends again right away
        ip_r <= (ip_r & ~(claim_rd ? claim_vec : '0)) | i_irq_request;
        if (access && i_apbi.pwrite && reg_idx == REG_ENABLE)
        begin
            ie_r <= i_apbi.pwdata[soc_cfg_pkg::IRQ_TOTAL-1:0];
        end
    end
end: regs_proc

always_comb
begin: read_proc
    o_apbo.prdata = '0;
    o_apbo.pready = 1'b1;
    o_apbo.pslverr = 1'b0;
    case (reg_idx)
    REG_PENDING: o_apbo.prdata = types_amba_pkg::apb_data_t'(ip_r);
    REG_ENABLE: o_apbo.prdata = types_amba_pkg::apb_data_t'(ie_r);
    REG_CLAIM: o_apbo.prdata = types_amba_pkg::apb_data_t'(claim_id);
    default: o_apbo.prdata = '0;
    endcase
end: read_proc

assign o_meip = |active;

// Claimed source whose request has dropped leaves pending
a_claim_clears: assert property (
    @(posedge i_clk) disable iff (i_rst)
    claim_rd && (claim_vec & ~i_irq_request) != '0 |=> (ip_r & $past(claim_vec)) == '0);

endmodule: apb_irqctrl

`default_nettype wire

// ==== rtl/apb_pnp.sv ====
// APB plug-and-play block
// Read-only hardware id, slot count and device descriptor table,
// plus one software interrupt bit that drives its interrupt line

`timescale 1ns/10ps
`default_nettype none

module apb_pnp (
    input logic i_clk,
    input logic i_rst,
    input types_amba_pkg::apb_in_type i_apbi,
    output types_amba_pkg::apb_out_type o_apbo,
    output logic o_irq
);

localparam soc_cfg_pkg::reg_idx_t REG_HWID = 'h0;
localparam soc_cfg_pkg::reg_idx_t REG_SLOTS = 'h1;
localparam soc_cfg_pkg::reg_idx_t REG_SWIRQ = 'h2;
localparam int REG_TABLE = 4;               // 0x10 and up with two words per slot

soc_cfg_pkg::reg_idx_t reg_idx;
logic swirq_r;

assign reg_idx = i_apbi.paddr[soc_cfg_pkg::SLOT_SIZE_LOG2-1:2];

always_ff @(posedge i_clk)
begin: swirq_proc
    if (i_rst)
    begin
        swirq_r <= 1'b0;
    end
    else if (i_apbi.psel && i_apbi.penable && i_apbi.pwrite && reg_idx == REG_SWIRQ)
    begin
        swirq_r <= i_apbi.pwdata[0];
    end
end: swirq_proc

always_comb
begin: read_proc
    o_apbo.prdata = '0;                     // Unused offsets read 0
    o_apbo.pready = 1'b1;
    o_apbo.pslverr = 1'b0;
    case (reg_idx)
    REG_HWID: o_apbo.prdata = soc_cfg_pkg::HW_ID;
    REG_SLOTS: o_apbo.prdata = types_amba_pkg::apb_data_t'(soc_cfg_pkg::SLOT_TOTAL);
    REG_SWIRQ: o_apbo.prdata = types_amba_pkg::apb_data_t'(swirq_r);
    default:
    begin
        for (int k = 0; k < soc_cfg_pkg::SLOT_TOTAL; k++)
        begin
            if (reg_idx == soc_cfg_pkg::reg_idx_t'(REG_TABLE + 2 * k))
            begin
                o_apbo.prdata = {soc_cfg_pkg::DEV_TABLE[k].vid, soc_cfg_pkg::DEV_TABLE[k].did};
            end
            if (reg_idx == soc_cfg_pkg::reg_idx_t'(REG_TABLE + 2 * k + 1))
            begin
                o_apbo.prdata = soc_cfg_pkg::DEV_TABLE[k].addr_base;
            end
        end
    end
    endcase
end: read_proc

assign o_irq = swirq_r;

endmodule: apb_pnp

`default_nettype wire

// ==== rtl/periph_soc.sv ====
// Peripheral subsystem top level
// APB decoder feeding GPIO, interrupt controller and plug-and-play
// slaves. GPIO and software interrupts form the controller source vector

`timescale 1ns/10ps
`default_nettype none

module periph_soc #(
    parameter int gpio_width = 12
)
(
    input logic i_sys_clk,                                  // System bus clock
    input logic i_rst,
    input types_amba_pkg::apb_in_type i_apbi,
    output types_amba_pkg::apb_out_type o_apbo,
    input logic [gpio_width-1:0] i_gpio,
    output logic [gpio_width-1:0] o_gpio,
    output logic [gpio_width-1:0] o_gpio_dir,
    output logic o_meip                                     // Machine external interrupt
);

types_amba_pkg::apb_in_type slv_apbi [soc_cfg_pkg::SLOT_TOTAL];
types_amba_pkg::apb_out_type slv_apbo [soc_cfg_pkg::SLOT_TOTAL];
logic [gpio_width-1:0] gpio_irq;
logic pnp_irq;
soc_cfg_pkg::irq_vec_t irq_vec;

apb_bus1 bus1 (
    .i_clk(i_sys_clk),
    .i_rst(i_rst),
    .i_apbi(i_apbi),
    .o_apbo(o_apbo),
    .o_slv_apbi(slv_apbi),
    .i_slv_apbo(slv_apbo)
);

apb_gpio #(
    .gpio_width(gpio_width)
) gpio0 (
    .i_clk(i_sys_clk),
    .i_rst(i_rst),
    .i_apbi(slv_apbi[soc_cfg_pkg::SLOT_GPIO]),
    .o_apbo(slv_apbo[soc_cfg_pkg::SLOT_GPIO]),
    .i_gpio(i_gpio),
    .o_gpio(o_gpio),
    .o_gpio_dir(o_gpio_dir),
    .o_irq(gpio_irq)
);

apb_irqctrl irqctrl0 (
    .i_clk(i_sys_clk),
    .i_rst(i_rst),
    .i_apbi(slv_apbi[soc_cfg_pkg::SLOT_IRQCTRL]),
    .o_apbo(slv_apbo[soc_cfg_pkg::SLOT_IRQCTRL]),
    .i_irq_request(irq_vec),
    .o_meip(o_meip)
);

apb_pnp pnp0 (
    .i_clk(i_sys_clk),
    .i_rst(i_rst),
    .i_apbi(slv_apbi[soc_cfg_pkg::SLOT_PNP]),
    .o_apbo(slv_apbo[soc_cfg_pkg::SLOT_PNP]),
    .o_irq(pnp_irq)
);

always_comb
begin: irq_proc
    irq_vec = '0;                                           // Unused sources tied low
    irq_vec[soc_cfg_pkg::IRQ_GPIO_BASE +: gpio_width] = gpio_irq;
    irq_vec[soc_cfg_pkg::IRQ_PNP] = pnp_irq;
end: irq_proc

endmodule: periph_soc

`default_nettype wire

// ==== dv/periph_checker.sv ====
// Peripheral subsystem checker
// Register model of the GPIO, interrupt controller and plug-and-play
// slaves, updated every clock edge from the observed APB traffic.
// Compares read data, responses, pins and the external interrupt

`timescale 1ns/10ps
`default_nettype none

module periph_checker #(
    parameter int gpio_width = 12
)
(
    input logic i_clk,
    input logic i_rst,
    input types_amba_pkg::apb_in_type i_apbi,
    input types_amba_pkg::apb_out_type i_apbo,
    input logic [gpio_width-1:0] i_gpio,
    input logic [gpio_width-1:0] i_gpio_out,
    input logic [gpio_width-1:0] i_gpio_dir,
    input logic i_meip,
    output int o_err_count,
    output int o_check_count
);

typedef logic [gpio_width-1:0] gpio_vec_t;

gpio_vec_t in_hist1;                        // i_gpio one edge back
gpio_vec_t in_hist2;                        // Two edges back like the input register
gpio_vec_t in_hist3;
gpio_vec_t m_out;
gpio_vec_t m_dir;
gpio_vec_t m_gie;
gpio_vec_t m_gip;
soc_cfg_pkg::irq_vec_t m_ip;
soc_cfg_pkg::irq_vec_t m_ie;
logic m_swirq;

initial
begin
    o_err_count = 0;
    o_check_count = 0;
end

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    o_check_count++;
    if (got !== exp)
    begin
        o_err_count++;
        $display("ERR %s got=%h expected=%h at %0t", name, got, exp, $time);
    end
endtask

// Lowest active source plus 1 or 0 when none is active
function automatic int claim_id(input soc_cfg_pkg::irq_vec_t act);
    int id;
    id = 0;
    for (int i = 0; i < soc_cfg_pkg::IRQ_TOTAL; i++)
    begin
        if (act[i] && id == 0)
        begin
            id = i + 1;
        end
    end
    return id;
endfunction

function automatic types_amba_pkg::apb_data_t expected_read(input types_amba_pkg::apb_addr_t addr);
    types_amba_pkg::apb_data_t value;
    logic [11:0] offs;
    value = '0;
    offs = {addr[11:2], 2'b00};
    case (addr[31:12])
    20'h0:
        case (offs)
        12'h000: value = in_hist2;
        12'h004: value = m_out;
        12'h008: value = m_dir;
        12'h00c: value = m_gie;
        12'h010: value = m_gip;
        default: value = '0;
        endcase
    20'h1:
        case (offs)
        12'h000: value = m_ip;
        12'h004: value = m_ie;
        12'h008: value = claim_id(m_ip & m_ie);
        default: value = '0;
        endcase
    20'h2:
    begin
        if (offs == 12'h000)
        begin
            value = soc_cfg_pkg::HW_ID;
        end
        if (offs == 12'h004)
        begin
            value = soc_cfg_pkg::SLOT_TOTAL;
        end
        if (offs == 12'h008)
        begin
            value = m_swirq;
        end
        for (int k = 0; k < soc_cfg_pkg::SLOT_TOTAL; k++)
        begin
            if (offs == 12'(16 + 8 * k))
            begin
                value = {soc_cfg_pkg::DEV_TABLE[k].vid, soc_cfg_pkg::DEV_TABLE[k].did};
            end
            if (offs == 12'(20 + 8 * k))
            begin
                value = soc_cfg_pkg::DEV_TABLE[k].addr_base;
            end
        end
    end
    default: value = '0;
    endcase
    return value;
endfunction

always @(posedge i_clk)
begin: model_proc
    soc_cfg_pkg::irq_vec_t claimed;
    soc_cfg_pkg::irq_vec_t src;
    gpio_vec_t clr;
    types_amba_pkg::apb_addr_t waddr;
    logic access;
    logic mapped;
    int id;
    if (i_rst)
    begin
        in_hist1 <= '0;
        in_hist2 <= '0;
        in_hist3 <= '0;
        m_out <= '0;
        m_dir <= '0;
        m_gie <= '0;
        m_gip <= '0;
        m_ip <= '0;
        m_ie <= '0;
        m_swirq <= 1'b0;
    end
    else
    begin
        access = i_apbi.psel && i_apbi.penable;
        mapped = i_apbi.paddr[31:12] < soc_cfg_pkg::SLOT_TOTAL;
        waddr = {i_apbi.paddr[31:2], 2'b00};
        check_value("o_gpio", i_gpio_out, m_out);
        check_value("o_gpio_dir", i_gpio_dir, m_dir);
        check_value("o_meip", i_meip, |(m_ip & m_ie));
        if (access)
        begin
            check_value("pready", i_apbo.pready, 1'b1);     // First access cycle
            check_value("pslverr", i_apbo.pslverr, !mapped);
            if (!mapped)
                check_value("prdata", i_apbo.prdata, '0);
            else if (!i_apbi.pwrite)
                check_value("prdata", i_apbo.prdata, expected_read(i_apbi.paddr));
        end
        claimed = '0;
        clr = '0;
        if (access && !i_apbi.pwrite && waddr == 32'h0000_1008)
        begin
            id = claim_id(m_ip & m_ie);
            if (id > 0)
                claimed[id-1] = 1'b1;
        end
        src = '0;
        src[soc_cfg_pkg::IRQ_GPIO_BASE +: gpio_width] = m_gip & m_gie;
        src[soc_cfg_pkg::IRQ_PNP] = m_swirq;
        if (access && i_apbi.pwrite)
        begin
            case (waddr)
            32'h0000_0004: m_out <= i_apbi.pwdata[gpio_width-1:0];
            32'h0000_0008: m_dir <= i_apbi.pwdata[gpio_width-1:0];
            32'h0000_000c: m_gie <= i_apbi.pwdata[gpio_width-1:0];
            32'h0000_0010: clr = i_apbi.pwdata[gpio_width-1:0];
            32'h0000_1004: m_ie <= i_apbi.pwdata[soc_cfg_pkg::IRQ_TOTAL-1:0];
            32'h0000_2008: m_swirq <= i_apbi.pwdata[0];
            default: ;
            endcase
        end
        m_gip <= (m_gip & ~clr) | (in_hist2 & ~in_hist3);  // Edge wins over clear
        m_ip <= (m_ip & ~claimed) | src;
        in_hist1 <= i_gpio;
        in_hist2 <= in_hist1;
        in_hist3 <= in_hist2;
    end
end: model_proc

endmodule: periph_checker

`default_nettype wire

// ==== dv/tb_periph_soc.sv ====
// Peripheral subsystem testbench
// Random APB master over the mapped registers with some unmapped
// accesses, random GPIO input changes and a watchdog on the run time

`timescale 1ns/10ps
`default_nettype none

module tb_periph_soc;

localparam int GPIO_WIDTH = 12;
localparam int NUM_OPS = 600;
localparam int CLK_PERIOD = 4;              // ns
localparam int TIMEOUT_CYCLES = NUM_OPS * 4 + 200;
localparam int NUM_REGS = 17;

logic clk;
logic rst;
types_amba_pkg::apb_in_type apbi;
types_amba_pkg::apb_out_type apbo;
logic [GPIO_WIDTH-1:0] gpio_in;
logic [GPIO_WIDTH-1:0] gpio_out;
logic [GPIO_WIDTH-1:0] gpio_dir;
logic meip;
integer seed;
int error_count;
int check_count;

// Every register that the map defines
types_amba_pkg::apb_addr_t reg_addr [NUM_REGS] = '{
    32'h0000_0000, 32'h0000_0004, 32'h0000_0008, 32'h0000_000c, 32'h0000_0010,
    32'h0000_1000, 32'h0000_1004, 32'h0000_1008,
    32'h0000_2000, 32'h0000_2004, 32'h0000_2008,
    32'h0000_2010, 32'h0000_2014, 32'h0000_2018, 32'h0000_201c,
    32'h0000_2020, 32'h0000_2024
};

periph_soc #(
    .gpio_width(GPIO_WIDTH)
) i_periph_soc (
    .i_sys_clk(clk),
    .i_rst(rst),
    .i_apbi(apbi),
    .o_apbo(apbo),
    .i_gpio(gpio_in),
    .o_gpio(gpio_out),
    .o_gpio_dir(gpio_dir),
    .o_meip(meip)
);

periph_checker #(
    .gpio_width(GPIO_WIDTH)
) chk0 (
    .i_clk(clk),
    .i_rst(rst),
    .i_apbi(apbi),
    .i_apbo(apbo),
    .i_gpio(gpio_in),
    .i_gpio_out(gpio_out),
    .i_gpio_dir(gpio_dir),
    .i_meip(meip),
    .o_err_count(error_count),
    .o_check_count(check_count)
);

always #(CLK_PERIOD / 2) clk = ~clk;

// Setup and access phases starting just after a rising edge
task automatic apb_transfer(input types_amba_pkg::apb_addr_t addr, input logic write,
                            input types_amba_pkg::apb_data_t data);
    apbi.paddr <= addr;
    apbi.pwrite <= write;
    apbi.pwdata <= data;
    apbi.psel <= 1'b1;
    apbi.penable <= 1'b0;
    @(posedge clk);
    apbi.penable <= 1'b1;
    @(posedge clk);
    while (!apbo.pready)
        @(posedge clk);
    apbi.psel <= 1'b0;
    apbi.penable <= 1'b0;
endtask

initial
begin: stimulus_proc
    types_amba_pkg::apb_addr_t addr;
    int pick;
    clk = 1'b0;
    rst = 1'b1;
    apbi = '0;
    gpio_in = '0;
    seed = 91;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < NUM_OPS; n++)
    begin
        pick = $unsigned($random(seed)) % NUM_REGS;
        addr = reg_addr[pick];
        if (($random(seed) & 15) == 0)
            addr = 32'h0000_3000 | ($random(seed) & 32'h7fff_fffc);    // Above the map
        @(posedge clk);
        if (($random(seed) & 3) == 0)
            gpio_in <= GPIO_WIDTH'($random(seed));
        apb_transfer(addr, 1'($random(seed)), $random(seed));
    end
    repeat (4) @(posedge clk);
    $display("Checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0)
    begin
        $display("Simulation passed");
    end
    else
    begin
        $display("Simulation failed");
    end
    $finish;
end: stimulus_proc

initial
begin: watchdog_proc
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the APB sequence did not finish", TIMEOUT_CYCLES);
    $display("Checks: %0d  errors: %0d", check_count, error_count);
    $display("Simulation failed");
    $finish;
end: watchdog_proc

endmodule: tb_periph_soc

`default_nettype wire

// ==== sources.f ====
rtl/types_amba_pkg.sv
rtl/soc_cfg_pkg.sv
rtl/apb_bus1.sv
rtl/apb_gpio.sv
rtl/apb_irqctrl.sv
rtl/apb_pnp.sv
rtl/periph_soc.sv
dv/periph_checker.sv
dv/tb_periph_soc.sv
